//--- files.f
reconfig_pkg.sv
reconfig_cmd_if.sv
reconfig_user_if.sv
reconfig_ch_map.sv
reconfig_reg_bank.sv
reconfig_seq.sv
reconfig_top.sv
tb_clk_gen.sv
reconfig_assertions.sv
tb_reconfig_top.sv

//--- reconfig_assertions.sv
// protocol checks on the host register file
// go is a lone pulse, never issued while the sequencer is busy,
// and a read sees waitrequest for exactly one cycle
`timescale 1ns/1ps
`default_nettype none

module reconfig_assertions (
   input wire reconfig_clk,
   input wire reset,
   input wire go,
   input wire busy,
   input wire read,
   input wire waitrequest
);

   a_go_single: assert property (@(posedge reconfig_clk) disable iff (reset)
      go |=> !go)
      else $error("go stayed high for more than one cycle");

   a_go_idle: assert property (@(posedge reconfig_clk) disable iff (reset)
      go |-> !busy)
      else $error("go issued while the sequencer was busy");

   // second read cycle carries the data
   a_wait_one: assert property (@(posedge reconfig_clk) disable iff (reset)
      (read && waitrequest) |=> !waitrequest)
      else $error("waitrequest held past the first read cycle");

endmodule

bind reconfig_user_if reconfig_assertions u_assertions (
   .reconfig_clk(reconfig_clk),
   .reset(reset),
   .go(cmd.go),
   .busy(busy),
   .read(read),
   .waitrequest(waitrequest)
);

`default_nettype wire

//--- reconfig_ch_map.sv
// logical to physical channel map
// registers the table entry and a range check on go,
// rewrites the entry when the sequencer commits a remap
`timescale 1ns/1ps
`default_nettype none

module reconfig_ch_map (
   input  wire                                  reconfig_clk,
   input  wire                                  reset,
   reconfig_cmd_if.unit                         cmd,
   input  wire                                  map_commit,
   output logic [reconfig_pkg::pch_width-1:0]   pch,
   output logic                                 lch_err
);

   logic [reconfig_pkg::pch_width-1:0] map_tbl [reconfig_pkg::lch_count];
   logic [reconfig_pkg::lch_sel_width-1:0] sel;  // table index from low lch bits

   assign sel = cmd.lch[reconfig_pkg::lch_sel_width-1:0];

   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         // default map runs backwards with lch 0 on pch 7
         for (int i = 0; i < reconfig_pkg::lch_count; i++)
            map_tbl[i] <= reconfig_pkg::pch_width'(reconfig_pkg::lch_count - 1 - i);
         pch <= '0;
         lch_err <= 1'b0;
      end
      else
      begin
         if (cmd.go)
         begin
            pch <= map_tbl[sel];
            lch_err <= (cmd.lch >= reconfig_pkg::lch_count);
         end
         if (map_commit)                       // only after a clean check
            map_tbl[sel] <= cmd.wdata[reconfig_pkg::pch_width-1:0];
      end
   end

endmodule

`default_nettype wire

//--- reconfig_cmd_if.sv
// reconfiguration command bundle
// carries one command from the host register file to the
// channel map, the register bank and the sequencer
`timescale 1ns/1ps
`default_nettype none

interface reconfig_cmd_if;

   logic                                 go;      // one-cycle start pulse
   logic [reconfig_pkg::mode_width-1:0]  mode;    // rd, wr or phy lookup
   logic [reconfig_pkg::lch_width-1:0]   lch;     // logical channel
   logic [reconfig_pkg::offset_width-1:0] offset;
   logic [reconfig_pkg::data_width-1:0]  wdata;
   logic [reconfig_pkg::ctrl_width-1:0]  ctrl;    // bank write or remap

   modport issuer (output go, mode, lch, offset, wdata, ctrl);
   modport unit   (input go, mode, lch, offset, wdata, ctrl);
   modport seq    (input go, mode, lch, offset, wdata, ctrl);

endinterface

`default_nettype wire

//--- reconfig_pkg.sv
// transceiver reconfiguration shared definitions
// host register map, operation codes, table sizes and the
// status word union used by the host register interface
`default_nettype none

package reconfig_pkg;

   localparam int data_width   = 32;   // host and bank word width
   localparam int addr_width   = 3;    // host address width
   localparam int offset_width = 5;    // offset register width
   localparam int lch_width    = 10;   // logical channel register width
   localparam int pch_width    = 4;    // physical channel number width
   localparam int ctrl_width   = 2;    // spare control field
   localparam int mode_width   = 3;

   localparam int lch_count     = 8;   // legal logical channels
   localparam int offset_count  = 16;  // legal offsets per channel
   localparam int lch_sel_width = 3;   // table index bits for lch_count
   localparam int off_sel_width = 4;   // bank index bits for offset_count

   // host register addresses 0 to 4 are the only legal ones
   localparam int addr_lch    = 0;
   localparam int addr_pch    = 1;
   localparam int addr_status = 2;
   localparam int addr_offset = 3;
   localparam int addr_data   = 4;

   localparam logic [mode_width-1:0] mode_rd  = 3'b000;
   localparam logic [mode_width-1:0] mode_wr  = 3'b001;
   localparam logic [mode_width-1:0] mode_phy = 3'b010;

   localparam logic [ctrl_width-1:0] ctrl_bank  = 2'd0;  // write goes to the register bank
   localparam logic [ctrl_width-1:0] ctrl_remap = 2'd1;  // write remaps the channel table

   // status address word, decoded differently on write and on read
   typedef union packed {
      struct packed {
         logic [27:0]           rsvd;
         logic [ctrl_width-1:0] ctrl;      // bits 3:2
         logic                  start_rd;  // bit 1
         logic                  start_wr;  // bit 0
      } wr;
      struct packed {
         logic [21:0]           rsvd_hi;
         logic                  error;     // bit 9
         logic                  busy;      // bit 8
         logic [3:0]            rsvd_mid;
         logic [ctrl_width-1:0] ctrl;      // bits 3:2
         logic [1:0]            rsvd_lo;
      } rd;
   } reconfig_status_u;

endpackage

`default_nettype wire

//--- reconfig_reg_bank.sv
// per-channel register bank
// lch_count channels by offset_count words, read on go with an
// offset range check, written when the sequencer commits
`timescale 1ns/1ps
`default_nettype none

module reconfig_reg_bank (
   input  wire                                  reconfig_clk,
   input  wire                                  reset,
   reconfig_cmd_if.unit                         cmd,
   input  wire                                  bank_commit,
   output logic [reconfig_pkg::data_width-1:0]  rdata,
   output logic                                 off_err
);

   localparam int depth = reconfig_pkg::lch_count * reconfig_pkg::offset_count;

   logic [reconfig_pkg::data_width-1:0] mem [depth];
   logic [reconfig_pkg::lch_sel_width+reconfig_pkg::off_sel_width-1:0] widx;

   // channel in the upper bits, offset in the lower
   assign widx = {cmd.lch[reconfig_pkg::lch_sel_width-1:0],
                  cmd.offset[reconfig_pkg::off_sel_width-1:0]};

   always_ff @(posedge reconfig_clk)
   begin
      if (bank_commit)                      // never raised for a bad lch
         mem[widx] <= cmd.wdata;
   end

   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         rdata <= '0;
         off_err <= 1'b0;
      end
      else if (cmd.go)
      begin
         rdata <= mem[widx];
         off_err <= (cmd.offset >= reconfig_pkg::offset_count);
      end
   end

endmodule

`default_nettype wire

//--- reconfig_seq.sv
// reconfiguration sequencer
// counts a command through check, commit and finish, merges
// the map and bank checks, pulses one commit and returns data
`timescale 1ns/1ps
`default_nettype none

module reconfig_seq (
   input  wire                                  reconfig_clk,
   input  wire                                  reset,
   reconfig_cmd_if.seq                          cmd,
   input  wire [reconfig_pkg::pch_width-1:0]    pch,
   input  wire                                  lch_err,
   input  wire [reconfig_pkg::data_width-1:0]   rdata,
   input  wire                                  off_err_in,
   output logic                                 map_commit,
   output logic                                 bank_commit,
   output logic                                 busy,
   output logic                                 pch_err,
   output logic                                 off_err,
   output logic [reconfig_pkg::data_width-1:0]  readdata,
   output logic [reconfig_pkg::data_width-1:0]  phreaddata
);

   logic [1:0] cnt;        // 0 idle, 1 check, 2 commit, 3 finish
   logic       wr_ok;

   assign busy = (cnt != 2'd0);
   assign wr_ok = (cmd.mode == reconfig_pkg::mode_wr) && !lch_err && !off_err_in;

   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         cnt <= 2'd0;
         map_commit <= 1'b0;
         bank_commit <= 1'b0;
         pch_err <= 1'b0;
         off_err <= 1'b0;
         readdata <= '0;
         phreaddata <= '0;
      end
      else
      begin
         map_commit <= 1'b0;
         bank_commit <= 1'b0;
         case (cnt)
            2'd0: if (cmd.go) cnt <= 2'd1;
            2'd1:
            begin
               cnt <= 2'd2;
               bank_commit <= wr_ok && (cmd.ctrl == reconfig_pkg::ctrl_bank);
               map_commit <= wr_ok && (cmd.ctrl == reconfig_pkg::ctrl_remap);
               pch_err <= lch_err;
               off_err <= (cmd.mode == reconfig_pkg::mode_phy) ? 1'b0 : off_err_in; // lookup ignores offset
               if (cmd.mode == reconfig_pkg::mode_rd)
                  readdata <= rdata;
               if (cmd.mode == reconfig_pkg::mode_phy)
                  phreaddata <= {{(reconfig_pkg::data_width-reconfig_pkg::pch_width){1'b0}}, pch};
            end
            2'd2: cnt <= 2'd3;                // commit lands on this edge
            default: cnt <= 2'd0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- reconfig_top.sv
// transceiver reconfiguration subsystem top level
// host register port on plain wires, command bundle shared by
// the channel map, the register bank and the sequencer
`timescale 1ns/1ps
`default_nettype none

module reconfig_top (
   input  wire                                  reconfig_clk,
   input  wire                                  reset,
   input  wire [reconfig_pkg::addr_width-1:0]   address,
   input  wire [reconfig_pkg::data_width-1:0]   writedata,
   input  wire                                  write,
   input  wire                                  read,
   output wire [reconfig_pkg::data_width-1:0]   readdata,
   output wire                                  waitrequest,
   output wire                                  done
);

   wire [reconfig_pkg::pch_width-1:0]  pch;
   wire                                lch_err;
   wire [reconfig_pkg::data_width-1:0] rdata;         // bank word at go
   wire                                off_err;       // bank check, raw
   wire                                map_commit;
   wire                                bank_commit;
   wire                                busy;
   wire                                pch_err;
   wire                                off_err_q;     // latched by the sequencer
   wire [reconfig_pkg::data_width-1:0] seq_readdata;
   wire [reconfig_pkg::data_width-1:0] phreaddata;

   reconfig_cmd_if cmd_if ();

   reconfig_user_if u_user_if (
      .reconfig_clk(reconfig_clk), .reset(reset),
      .address(address), .writedata(writedata), .write(write), .read(read),
      .readdata(readdata), .waitrequest(waitrequest), .done(done),
      .cmd(cmd_if.issuer),
      .busy(busy), .pch_err(pch_err), .off_err(off_err_q),
      .rdata_in(seq_readdata), .phreaddata(phreaddata)
   );

   reconfig_ch_map u_ch_map (
      .reconfig_clk(reconfig_clk), .reset(reset), .cmd(cmd_if.unit),
      .map_commit(map_commit), .pch(pch), .lch_err(lch_err)
   );

   reconfig_reg_bank u_reg_bank (
      .reconfig_clk(reconfig_clk), .reset(reset), .cmd(cmd_if.unit),
      .bank_commit(bank_commit), .rdata(rdata), .off_err(off_err)
   );

   reconfig_seq u_seq (
      .reconfig_clk(reconfig_clk), .reset(reset), .cmd(cmd_if.seq),
      .pch(pch), .lch_err(lch_err), .rdata(rdata), .off_err_in(off_err),
      .map_commit(map_commit), .bank_commit(bank_commit), .busy(busy),
      .pch_err(pch_err), .off_err(off_err_q),
      .readdata(seq_readdata), .phreaddata(phreaddata)
   );

endmodule

`default_nettype wire

//--- reconfig_user_if.sv
// host register file for the reconfiguration subsystem
// decodes the avalon-style host port, latches channel, offset
// and data, issues go pulses and builds the read data
// reads take one waitrequest cycle, writes take none
`timescale 1ns/1ps
`default_nettype none

module reconfig_user_if (
   input  wire                                  reconfig_clk,
   input  wire                                  reset,
   input  wire [reconfig_pkg::addr_width-1:0]   address,
   input  wire [reconfig_pkg::data_width-1:0]   writedata,
   input  wire                                  write,
   input  wire                                  read,
   output logic [reconfig_pkg::data_width-1:0]  readdata,
   output logic                                 waitrequest,
   output logic                                 done,
   reconfig_cmd_if.issuer                       cmd,
   input  wire                                  busy,
   input  wire                                  pch_err,
   input  wire                                  off_err,
   input  wire [reconfig_pkg::data_width-1:0]   rdata_in,
   input  wire [reconfig_pkg::data_width-1:0]   phreaddata
);

   reconfig_pkg::reconfig_status_u wr_word;  // host word, write view
   reconfig_pkg::reconfig_status_u rd_word;  // status word, read view
   logic illegal_addr;                       // last access hit 5..7
   logic read_ack;                           // second cycle of a read
   logic idle;

   assign wr_word = writedata;
   assign idle = !busy && !cmd.go;           // go cycle counts as busy too
   assign done = !busy;
   assign waitrequest = read && !read_ack;   // high only in first read cycle

   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
         read_ack <= 1'b0;
      else
         read_ack <= read && !read_ack;
   end

   always_comb
   begin
      rd_word = '0;
      rd_word.rd.ctrl = cmd.ctrl;
      rd_word.rd.busy = busy;
      rd_word.rd.error = illegal_addr || pch_err || off_err;
   end

   // register writes and command launch
   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
      begin
         cmd.go <= 1'b0;
         cmd.mode <= reconfig_pkg::mode_rd;
         cmd.lch <= '0;
         cmd.offset <= '0;
         cmd.wdata <= '0;
         cmd.ctrl <= '0;
         illegal_addr <= 1'b0;
      end
      else
      begin
         cmd.go <= 1'b0;                      // pulse unless set below
         if (write || read)
            illegal_addr <= (address > reconfig_pkg::addr_data);
         case (address)
            reconfig_pkg::addr_lch:
               if (write && idle)
                  cmd.lch <= writedata[reconfig_pkg::lch_width-1:0];
            reconfig_pkg::addr_offset:
               if (write && idle)
                  cmd.offset <= writedata[reconfig_pkg::offset_width-1:0];
            reconfig_pkg::addr_data:
               if (write && idle)
                  cmd.wdata <= writedata;
            reconfig_pkg::addr_status:
               if (write && idle)
               begin
                  if (wr_word.wr.start_wr)    // write wins over read
                  begin
                     cmd.go <= 1'b1;
                     cmd.mode <= reconfig_pkg::mode_wr;
                     cmd.ctrl <= wr_word.wr.ctrl;
                  end
                  else if (wr_word.wr.start_rd)
                  begin
                     cmd.go <= 1'b1;
                     cmd.mode <= reconfig_pkg::mode_rd;
                     cmd.ctrl <= wr_word.wr.ctrl;
                  end
               end
            reconfig_pkg::addr_pch:
               if (read && waitrequest && idle) // lookup launched once per read
               begin
                  cmd.go <= 1'b1;
                  cmd.mode <= reconfig_pkg::mode_phy;
               end
            default:
               ;
         endcase
      end
   end

   // read data sampled at the end of the waitrequest cycle
   always_ff @(posedge reconfig_clk or posedge reset)
   begin
      if (reset)
         readdata <= '0;
      else if (read && waitrequest)
      begin
         case (address)
            reconfig_pkg::addr_lch:
               readdata <= {{(reconfig_pkg::data_width-reconfig_pkg::lch_width){1'b0}}, cmd.lch};
            reconfig_pkg::addr_pch:
               if (!busy)
                  readdata <= phreaddata;     // old value while busy
            reconfig_pkg::addr_status:
               readdata <= rd_word;
            reconfig_pkg::addr_offset:
               readdata <= {{(reconfig_pkg::data_width-reconfig_pkg::offset_width){1'b0}},
                            cmd.offset};
            reconfig_pkg::addr_data:
               if (!busy)
               begin
                  if (cmd.mode == reconfig_pkg::mode_wr)
                     readdata <= cmd.wdata;   // echo of the last write
                  else if (cmd.mode == reconfig_pkg::mode_rd)
                     readdata <= rdata_in;
               end
            default:
               readdata <= '0;                // reserved addresses read zero
         endcase
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the reconfiguration testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_reconfig_top \
   -o tb_reconfig_top
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/tb_reconfig_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TB FAILED" sim.log; then
   exit 1
fi
grep -q "TB PASSED" sim.log || exit 1
exit 0

//--- tb_clk_gen.sv
// testbench clock and reset source
// 4 ns reconfig clock, reset held high for the first two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic reconfig_clk,
   output logic reset
);

   initial
   begin
      reconfig_clk = 1'b0;
      forever #2 reconfig_clk = ~reconfig_clk;  // 4 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (2) @(posedge reconfig_clk);
      @(negedge reconfig_clk);
      reset = 1'b0;                             // released between edges
   end

endmodule

`default_nettype wire

//--- tb_reconfig_top.sv
// testbench for the reconfiguration subsystem
// drives the avalon-style host port on falling edges, keeps a
// model of the bank, the channel map and the host registers,
// and compares every host read against that model
`timescale 1ns/1ps
`default_nettype none

module tb_reconfig_top;

   logic        reconfig_clk;
   logic        reset;
   logic [2:0]  address;
   logic [31:0] writedata;
   logic        write;
   logic        read;
   wire  [31:0] readdata;
   wire         waitrequest;
   wire         done;

   integer seed;
   int     errors;
   int     timeouts;

   // model state
   logic [31:0] bank_m [reconfig_pkg::lch_count][reconfig_pkg::offset_count];
   logic [3:0]  map_m [reconfig_pkg::lch_count];
   logic [9:0]  lch_m;
   logic [4:0]  off_m;
   logic [31:0] data_m;
   logic [1:0]  ctrl_m;
   logic [2:0]  mode_m;
   logic [31:0] rd_m;        // bank word of the last read command
   logic [31:0] ph_m;        // result of the last lookup
   logic [31:0] last_rd_m;   // host readdata register
   logic        busy_m;
   logic        illegal_m;
   logic        pch_err_m;
   logic        off_err_m;

   // hand-off to the compare process
   event        read_ev;
   logic [31:0] exp_v;
   logic [31:0] act_v;
   string       name_v;

   tb_clk_gen u_clk_gen (.reconfig_clk(reconfig_clk), .reset(reset));

   reconfig_top i_dut (
      .reconfig_clk(reconfig_clk), .reset(reset),
      .address(address), .writedata(writedata), .write(write), .read(read),
      .readdata(readdata), .waitrequest(waitrequest), .done(done)
   );

   // applies one command to the model the way the sequencer does
   function automatic void run_command(input logic [2:0] mode);
      logic       lerr;
      logic       oerr;
      logic [2:0] ch;
      logic [3:0] of;
      ch = lch_m[2:0];
      of = off_m[3:0];
      lerr = (lch_m > 10'd7);
      oerr = (off_m > 5'd15);
      mode_m = mode;
      busy_m = 1'b1;
      pch_err_m = lerr;
      off_err_m = (mode == reconfig_pkg::mode_phy) ? 1'b0 : oerr;
      if (mode == reconfig_pkg::mode_wr && !lerr && !oerr)
      begin
         if (ctrl_m == 2'd0)
            bank_m[ch][of] = data_m;
         else if (ctrl_m == 2'd1)
            map_m[ch] = data_m[3:0];   // remap takes the low nibble
      end
      if (mode == reconfig_pkg::mode_rd)
         rd_m = bank_m[ch][of];
      if (mode == reconfig_pkg::mode_phy)
         ph_m = {28'd0, map_m[ch]};
   endfunction

   function automatic void track_write(input logic [2:0] addr, input logic [31:0] data);
      illegal_m = (addr > 3'd4);
      if (!busy_m)                     // writes ignored while busy
      begin
         case (addr)
            3'd0: lch_m = data[9:0];
            3'd3: off_m = data[4:0];
            3'd4: data_m = data;
            3'd2:
               if (data[0] || data[1])
               begin
                  ctrl_m = data[3:2];
                  run_command(data[0] ? reconfig_pkg::mode_wr : reconfig_pkg::mode_rd);
               end
            default: ;
         endcase
      end
   endfunction

   function automatic void track_read(input logic [2:0] addr);
      illegal_m = (addr > 3'd4);
      if (addr == 3'd1 && !busy_m)
         run_command(reconfig_pkg::mode_phy);  // pch read starts a lookup
   endfunction

   // expected host readdata from the model before the access
   function automatic logic [31:0] expect_read(input logic [2:0] addr);
      logic [31:0] v;
      v = 32'd0;
      case (addr)
         3'd0: v = {22'd0, lch_m};
         3'd1: v = busy_m ? last_rd_m : ph_m;
         3'd2:
         begin
            v[9] = illegal_m | pch_err_m | off_err_m;
            v[8] = busy_m;
            v[3:2] = ctrl_m;
         end
         3'd3: v = {27'd0, off_m};
         3'd4:
            if (busy_m || mode_m == reconfig_pkg::mode_phy)
               v = last_rd_m;          // readdata register keeps its value
            else if (mode_m == reconfig_pkg::mode_wr)
               v = data_m;
            else
               v = rd_m;
         default: v = 32'd0;
      endcase
      return v;
   endfunction

   // all host tasks start and end on a falling edge
   task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
      address = addr;
      writedata = data;
      write = 1'b1;
      @(negedge reconfig_clk);
      write = 1'b0;
      track_write(addr, data);
   endtask

   task automatic host_read(input logic [2:0] addr, input string name);
      logic [31:0] exp;
      int          n;
      exp = expect_read(addr);
      address = addr;
      read = 1'b1;
      n = 0;
      @(negedge reconfig_clk);
      while (waitrequest && n < 8)
      begin
         @(negedge reconfig_clk);
         n++;
      end
      if (waitrequest)
      begin
         $display("timeout: waitrequest stayed high on a read of address %0d", addr);
         timeouts++;
      end
      act_v = readdata;
      exp_v = exp;
      name_v = name;
      read = 1'b0;
      -> read_ev;
      last_rd_m = exp;
      track_read(addr);
      @(negedge reconfig_clk);         // idle cycle between reads
   endtask

   task automatic start_cmd(input logic [31:0] word);
      host_write(3'd2, word);
      @(negedge reconfig_clk);         // busy is up from here
   endtask

   task automatic wait_done;
      int n;
      n = 0;
      while (!done && n < 20)
      begin
         @(negedge reconfig_clk);
         n++;
      end
      if (!done)
      begin
         $display("timeout: done did not return after a command");
         timeouts++;
      end
      busy_m = 1'b0;
   endtask

   always @(read_ev)
   begin
      if (act_v !== exp_v)
      begin
         $display("Mismatch %s: expected %h, actual %h", name_v, exp_v, act_v);
         errors++;
      end
   end

   initial
   begin
      logic [31:0] rnd;
      logic [31:0] kept;
      logic [2:0]  ch;
      logic [3:0]  off;
      logic [2:0]  bad;
      int          n;
      address = 3'd0;
      writedata = 32'd0;
      write = 1'b0;
      read = 1'b0;
      seed = 32'h3303262c;
      errors = 0;
      timeouts = 0;
      for (int i = 0; i < reconfig_pkg::lch_count; i++)
         map_m[i] = 4'(7 - i);         // reset map runs backwards
      lch_m = '0;
      off_m = '0;
      data_m = '0;
      ctrl_m = '0;
      mode_m = reconfig_pkg::mode_rd;
      rd_m = '0;
      ph_m = '0;
      last_rd_m = '0;
      busy_m = 1'b0;
      illegal_m = 1'b0;
      pch_err_m = 1'b0;
      off_err_m = 1'b0;
      kept = '0;
      ch = '0;
      off = '0;

      n = 0;
      @(negedge reconfig_clk);
      while (reset && n < 10)
      begin
         @(negedge reconfig_clk);
         n++;
      end
      if (reset)
      begin
         $display("timeout: reset was never released");
         timeouts++;
      end

      // register round trip
      host_read(3'd2, "status_reset");
      rnd = $random(seed);
      host_write(3'd0, rnd);
      host_read(3'd0, "lch_round_trip");
      rnd = $random(seed);
      host_write(3'd3, rnd);
      host_read(3'd3, "offset_round_trip");

      // bank write then read back
      for (int i = 0; i < 4; i++)
      begin
         rnd = $random(seed);
         ch = rnd[2:0];
         off = rnd[7:4];
         kept = $random(seed);
         host_write(3'd0, {29'd0, ch});
         host_write(3'd3, {28'd0, off});
         host_write(3'd4, kept);
         start_cmd(32'h1);
         wait_done;
         start_cmd(32'h2);
         wait_done;
         host_read(3'd4, "bank_read");
         host_read(3'd2, "bank_status");
      end

      // range errors must not touch the bank
      host_write(3'd0, 32'd8 + {29'd0, ch});  // bad channel on the same table slot
      host_write(3'd4, $random(seed));
      start_cmd(32'h1);
      wait_done;
      host_read(3'd2, "lch_error_status");
      host_write(3'd0, {29'd0, ch});
      host_write(3'd3, 32'd16 + {28'd0, off});
      start_cmd(32'h1);
      wait_done;
      host_read(3'd2, "offset_error_status");
      host_write(3'd3, {28'd0, off});
      start_cmd(32'h2);
      wait_done;
      host_read(3'd4, "bank_unchanged");
      host_read(3'd2, "error_cleared");

      // physical lookup then remap
      host_read(3'd1, "pch_before_lookup");
      wait_done;
      host_read(3'd1, "pch_lookup");
      wait_done;
      host_write(3'd4, $random(seed));
      start_cmd(32'h5);                        // write with ctrl = remap
      wait_done;
      host_read(3'd1, "pch_stale");
      wait_done;
      host_read(3'd1, "pch_remapped");
      wait_done;
      host_read(3'd2, "remap_status");

      // busy window
      host_write(3'd4, $random(seed));
      start_cmd(32'h1);
      if (done !== 1'b0)
      begin
         $display("Mismatch done_while_busy: expected 0, actual %b", done);
         errors++;
      end
      host_write(3'd4, $random(seed));         // must be dropped
      host_read(3'd2, "status_busy");
      wait_done;
      host_read(3'd4, "data_kept");
      host_read(3'd2, "status_idle");

      // illegal addresses
      rnd = $random(seed);
      bad = (rnd[1:0] == 2'd0) ? 3'd5 : ((rnd[1:0] == 2'd1) ? 3'd6 : 3'd7);
      host_write(bad, $random(seed));
      host_read(3'd2, "illegal_write_status");
      host_read(bad, "illegal_read");
      host_read(3'd2, "illegal_read_status");
      host_read(3'd0, "legal_access");
      host_read(3'd2, "illegal_cleared");

      @(negedge reconfig_clk);
      $display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire
